// ==== logic/rdl_defines.svh ====
// fixed geometry of two ways and four 64-bit beats per line; sizes here are not parameters
`ifndef RDL_DEFINES_SVH
`define RDL_DEFINES_SVH

// ==========================================================================
// line geometry
// ==========================================================================

// set index
`define RDL_INDEX_W 10

// stored tag, sits above the index in a line address
`define RDL_TAG_W 17

// line address, tag and index together
`define RDL_LINE_ADDR_W 27

// one beat of line data
`define RDL_DATA_W 64

// beat counter, four beats per line
`define RDL_BEAT_W 2

// ==========================================================================
// cache organisation and ids
// ==========================================================================

`define RDL_WAYS 2

// maintenance request id
`define RDL_ID_W 2

`endif

// ==== logic/rdl_pkg.sv ====
// types for the two-way line-read unit; widths follow the macros and are not meant to change
`include "rdl_defines.svh"

package rdl_pkg;

  typedef logic [`RDL_INDEX_W-1:0]     rdl_index_t;
  typedef logic [`RDL_TAG_W-1:0]       rdl_tag_t;
  typedef logic [`RDL_LINE_ADDR_W-1:0] rdl_line_addr_t;
  typedef logic [`RDL_DATA_W-1:0]      rdl_data_t;
  typedef logic [`RDL_BEAT_W-1:0]      rdl_beat_t;
  typedef logic [`RDL_ID_W-1:0]        rdl_id_t;

  // one bit per way
  typedef logic [`RDL_WAYS-1:0]        rdl_way_oh_t;

  // job engine states
  typedef enum logic [2:0] {
    IDLE   = 3'b000,
    CHECK  = 3'b001,
    DATA   = 3'b010,
    LAST   = 3'b011,
    TAG_RD = 3'b100,
    TAG_WT = 3'b101,
    INV    = 3'b110
  } rdl_state_e;

  // maintenance job from the store buffer
  typedef struct packed {
    rdl_line_addr_t line_addr;
    logic           cln;
    logic           inv;
    logic           dirty;
    logic           way;
    rdl_id_t        id;
  } rdl_stb_req_t;

  // per-way return from the tag, dirty and data arrays
  typedef struct packed {
    logic      vld;
    logic      dirty;
    rdl_tag_t  tag;
    rdl_data_t data;
  } rdl_way_rd_t;

  // request to the array arbiter
  typedef struct packed {
    logic        tag_req;
    logic        dirty_req;
    logic        data_req;
    rdl_way_oh_t tag_wen;
    rdl_way_oh_t dirty_wen;
    rdl_index_t  index;
    rdl_beat_t   beat;
    rdl_way_oh_t data_way;
  } rdl_arb_req_t;

  // victim buffer entry creation
  typedef struct packed {
    rdl_line_addr_t addr;
    logic           dirty;
  } rdl_vb_line_t;

  // one beat pushed into the victim buffer
  typedef struct packed {
    rdl_data_t data;
    rdl_beat_t beat;
  } rdl_vb_beat_t;

endpackage

// ==== logic/rdl_fsm.sv ====
// one job in flight; stb wins a tie with lfb; beat counter assumes exactly four beats per line
`timescale 1ns/1ps

module rdl_fsm import rdl_pkg::*; (
  input  logic       rdl_fsm_clk,
  input  logic       cpurst_b,
  input  logic       stb_start,
  input  logic       lfb_start,
  input  logic       arb_grant,
  input  logic       vb_grant,
  input  logic       dca_sel,
  input  logic       line_rd,
  input  logic       line_inv,
  output rdl_state_e state,
  output rdl_beat_t  beat,
  output logic       stb_grant,
  output logic       lfb_grant,
  output logic       take_stb,
  output logic       take_lfb,
  output logic       take_tag,
  output logic       vb_create,
  output logic       stb_cmplt,
  output logic       lfb_done,
  output logic       lfb_victim_save
);

  rdl_state_e next_state;
  logic       is_idle;
  logic       is_check;
  logic       is_data;
  logic       is_inv;
  logic       data_grant;
  logic       data_done;

  assign is_idle  = (state == IDLE);
  assign is_check = (state == CHECK);
  assign is_data  = (state == DATA);
  assign is_inv   = (state == INV);

  assign data_grant = is_data & arb_grant;
  // fourth beat granted
  assign data_done  = data_grant & (beat == '1);

  // ==========================================================================
  // state register
  // ==========================================================================

  always_ff @(posedge rdl_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (stb_start) begin
          next_state = CHECK;
        end else if (lfb_start) begin
          next_state = TAG_RD;
        end
      end
      TAG_RD: begin
        if (arb_grant) begin
          next_state = TAG_WT;
        end
      end
      // victim way latched here
      TAG_WT: next_state = CHECK;
      CHECK: begin
        if (line_rd) begin
          next_state = vb_grant ? DATA : CHECK;
        end else if (line_inv) begin
          next_state = INV;
        end else begin
          next_state = IDLE;
        end
      end
      DATA: begin
        if (data_done) begin
          next_state = dca_sel ? INV : LAST;
        end
      end
      // lets the last beat reach the victim buffer
      LAST: next_state = IDLE;
      INV: begin
        if (arb_grant) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  // beat counter wraps back to 0 after beat 3
  always_ff @(posedge rdl_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      beat <= '0;
    end else if (data_grant) begin
      beat <= beat + rdl_beat_t'(1);
    end
  end

  // ==========================================================================
  // handshakes
  // ==========================================================================

  assign stb_grant = is_idle;
  assign lfb_grant = is_idle & ~stb_start;
  assign take_stb  = stb_start & stb_grant;
  assign take_lfb  = lfb_start & lfb_grant;
  assign take_tag  = (state == TAG_WT);

  assign lfb_victim_save = take_tag;
  assign vb_create       = is_check & line_rd;

  // nothing to read or clear, finish straight from CHECK
  assign stb_cmplt = (is_inv & arb_grant) |
                     (is_check & dca_sel & ~line_rd & ~line_inv);
  assign lfb_done  = (is_check & ~dca_sel & ~line_rd) |
                     (data_done & ~dca_sel);

endmodule

// ==== logic/rdl_target_reg.sv ====
// stb lines are taken as valid; lfb line facts only hold once the TAG_WT capture has happened
`timescale 1ns/1ps
`include "rdl_defines.svh"

module rdl_target_reg import rdl_pkg::*; (
  input  logic         rdl_fsm_clk,
  input  logic         cpurst_b,
  input  logic         take_stb,
  input  logic         take_lfb,
  input  logic         take_tag,
  input  rdl_stb_req_t stb_req,
  input  rdl_index_t   lfb_index,
  input  rdl_way_rd_t  way0_rd,
  input  rdl_way_rd_t  way1_rd,
  input  logic         dc_victim_way,
  output logic         dca_sel,
  output logic         line_rd,
  output logic         line_inv,
  output rdl_index_t   index,
  output logic         way,
  output logic         inv_op,
  output rdl_vb_line_t vb_line,
  output rdl_id_t      stb_cmplt_id
);

  logic        dca_cln;
  logic        dca_inv;
  logic        line_vld;
  logic        line_dirty;
  rdl_tag_t    line_tag;
  rdl_id_t     dca_id;
  rdl_way_rd_t victim_rd;

  // way picked by the cache replacement
  assign victim_rd = dc_victim_way ? way1_rd : way0_rd;

  // ==========================================================================
  // job source and maintenance type
  // ==========================================================================

  always_ff @(posedge rdl_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      dca_sel <= 1'b0;
      dca_cln <= 1'b0;
      dca_inv <= 1'b0;
    end else if (take_stb) begin
      dca_sel <= 1'b1;
      dca_cln <= stb_req.cln;
      dca_inv <= stb_req.inv;
    end else if (take_lfb) begin
      dca_sel <= 1'b0;
      dca_cln <= 1'b0;
      dca_inv <= 1'b0;
    end
  end

  // line state, from the request or from the tag read
  always_ff @(posedge rdl_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      line_vld   <= 1'b0;
      line_dirty <= 1'b0;
    end else if (take_stb) begin
      line_vld   <= 1'b1;
      line_dirty <= stb_req.dirty;
    end else if (take_tag) begin
      line_vld   <= victim_rd.vld;
      line_dirty <= victim_rd.dirty;
    end
  end

  // set, tag, way and id
  always_ff @(posedge rdl_fsm_clk) begin
    if (take_stb) begin
      index    <= stb_req.line_addr[`RDL_INDEX_W-1:0];
      line_tag <= stb_req.line_addr[`RDL_LINE_ADDR_W-1:`RDL_INDEX_W];
      way      <= stb_req.way;
      dca_id   <= stb_req.id;
    end else if (take_lfb) begin
      index    <= lfb_index;
    end else if (take_tag) begin
      line_tag <= victim_rd.tag;
      way      <= dc_victim_way;
    end
  end

  // ==========================================================================
  // decisions
  // ==========================================================================

  // clean of a dirty line, or eviction of a valid victim
  assign line_rd  = (dca_sel & dca_cln & line_dirty) | (~dca_sel & line_vld);
  assign line_inv = dca_sel & dca_inv & line_vld;
  assign inv_op   = dca_inv;

  always_comb begin
    vb_line.addr  = {line_tag, index};
    vb_line.dirty = line_dirty;
  end

  assign stb_cmplt_id = dca_id;

endmodule

// ==== logic/rdl_array_access.sv ====
// requests are held purely by state; the returned beat is taken the cycle after its data grant
`timescale 1ns/1ps
`include "rdl_defines.svh"

module rdl_array_access import rdl_pkg::*; (
  input  logic         rdl_fsm_clk,
  input  logic         cpurst_b,
  input  rdl_state_e   state,
  input  rdl_beat_t    beat,
  input  logic         arb_grant,
  input  rdl_index_t   index,
  input  logic         way,
  input  logic         inv_op,
  input  rdl_way_rd_t  way0_rd,
  input  rdl_way_rd_t  way1_rd,
  output rdl_arb_req_t arb_req,
  output rdl_vb_beat_t vb_beat,
  output logic         vb_beat_vld
);

  rdl_way_oh_t way_oh;
  logic        tag_rd;
  logic        inv_st;
  logic        tag_clr;
  logic        data_rd;
  logic        data_grant;
  logic        beat_vld_q;
  rdl_beat_t   beat_q;

  assign way_oh  = {way, ~way};
  assign tag_rd  = (state == TAG_RD);
  assign inv_st  = (state == INV);
  assign data_rd = (state == DATA);
  // tag is only cleared when the job invalidates
  assign tag_clr = inv_st & inv_op;

  assign data_grant = data_rd & arb_grant;

  // ==========================================================================
  // array requests
  // ==========================================================================

  always_comb begin
    arb_req.tag_req   = tag_rd | tag_clr;
    arb_req.dirty_req = tag_rd | inv_st;
    arb_req.data_req  = data_rd;
    arb_req.tag_wen   = {`RDL_WAYS{tag_clr}} & way_oh;
    arb_req.dirty_wen = {`RDL_WAYS{inv_st}} & way_oh;
    arb_req.index     = index;
    arb_req.beat      = beat;
    arb_req.data_way  = way_oh;
  end

  // ==========================================================================
  // beat forwarding
  // ==========================================================================

  always_ff @(posedge rdl_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      beat_vld_q <= 1'b0;
    end else begin
      beat_vld_q <= data_grant;
    end
  end

  // beat number travels alongside the returning data
  always_ff @(posedge rdl_fsm_clk) begin
    if (data_grant) begin
      beat_q <= beat;
    end
  end

  assign vb_beat_vld = beat_vld_q;

  always_comb begin
    vb_beat.data = way ? way1_rd.data : way0_rd.data;
    vb_beat.beat = beat_q;
  end

endmodule

// ==== logic/rdl_top.sv ====
// single clock and one job at a time; grants from the arbiter and victim buffer may stall any step
`timescale 1ns/1ps

module rdl_top import rdl_pkg::*; (
  input  logic         rdl_fsm_clk,
  input  logic         cpurst_b,
  input  logic         stb_start,
  input  rdl_stb_req_t stb_req,
  input  logic         lfb_start,
  input  rdl_index_t   lfb_index,
  input  logic         arb_grant,
  input  rdl_way_rd_t  way0_rd,
  input  rdl_way_rd_t  way1_rd,
  input  logic         dc_victim_way,
  input  logic         vb_grant,
  output logic         stb_grant,
  output logic         stb_cmplt,
  output rdl_id_t      stb_cmplt_id,
  output logic         lfb_grant,
  output logic         lfb_done,
  output logic         lfb_victim_save,
  output logic         lfb_victim_way,
  output rdl_arb_req_t arb_req,
  output logic         vb_create,
  output rdl_vb_line_t vb_line,
  output rdl_vb_beat_t vb_beat,
  output logic         vb_beat_vld
);

  rdl_state_e state;
  rdl_beat_t  beat;
  logic       take_stb;
  logic       take_lfb;
  logic       take_tag;
  logic       dca_sel;
  logic       line_rd;
  logic       line_inv;
  rdl_index_t index;
  logic       way;
  logic       inv_op;

  // victim way goes back to the lfb as the array reports it
  assign lfb_victim_way = dc_victim_way;

  rdl_fsm u_fsm (
    .rdl_fsm_clk     (rdl_fsm_clk),
    .cpurst_b        (cpurst_b),
    .stb_start       (stb_start),
    .lfb_start       (lfb_start),
    .arb_grant       (arb_grant),
    .vb_grant        (vb_grant),
    .dca_sel         (dca_sel),
    .line_rd         (line_rd),
    .line_inv        (line_inv),
    .state           (state),
    .beat            (beat),
    .stb_grant       (stb_grant),
    .lfb_grant       (lfb_grant),
    .take_stb        (take_stb),
    .take_lfb        (take_lfb),
    .take_tag        (take_tag),
    .vb_create       (vb_create),
    .stb_cmplt       (stb_cmplt),
    .lfb_done        (lfb_done),
    .lfb_victim_save (lfb_victim_save)
  );

  rdl_target_reg u_target_reg (
    .rdl_fsm_clk   (rdl_fsm_clk),
    .cpurst_b      (cpurst_b),
    .take_stb      (take_stb),
    .take_lfb      (take_lfb),
    .take_tag      (take_tag),
    .stb_req       (stb_req),
    .lfb_index     (lfb_index),
    .way0_rd       (way0_rd),
    .way1_rd       (way1_rd),
    .dc_victim_way (dc_victim_way),
    .dca_sel       (dca_sel),
    .line_rd       (line_rd),
    .line_inv      (line_inv),
    .index         (index),
    .way           (way),
    .inv_op        (inv_op),
    .vb_line       (vb_line),
    .stb_cmplt_id  (stb_cmplt_id)
  );

  rdl_array_access u_array_access (
    .rdl_fsm_clk (rdl_fsm_clk),
    .cpurst_b    (cpurst_b),
    .state       (state),
    .beat        (beat),
    .arb_grant   (arb_grant),
    .index       (index),
    .way         (way),
    .inv_op      (inv_op),
    .way0_rd     (way0_rd),
    .way1_rd     (way1_rd),
    .arb_req     (arb_req),
    .vb_beat     (vb_beat),
    .vb_beat_vld (vb_beat_vld)
  );

endmodule

// ==== sim/rdl_checker.sv ====
// samples DUT ports on the falling clock edge; lfb victim facts come from the rdl_tb tag table
`timescale 1ns/1ps

module rdl_checker import rdl_pkg::*; (
  input logic         rdl_fsm_clk,
  input logic         cpurst_b,
  input logic         stb_start,
  input rdl_stb_req_t stb_req,
  input logic         stb_grant,
  input logic         stb_cmplt,
  input rdl_id_t      stb_cmplt_id,
  input logic         lfb_start,
  input rdl_index_t   lfb_index,
  input logic         lfb_grant,
  input logic         lfb_done,
  input logic         lfb_victim_save,
  input logic         lfb_victim_way,
  input logic         dc_victim_way,
  input rdl_arb_req_t arb_req,
  input logic         arb_grant,
  input logic         vb_create,
  input rdl_vb_line_t vb_line,
  input logic         vb_grant,
  input rdl_vb_beat_t vb_beat,
  input logic         vb_beat_vld
);

  int unsigned  err_cnt = 0;
  int unsigned  check_cnt = 0;
  rdl_vb_beat_t exp_beat_q[$];
  rdl_vb_line_t exp_line_q[$];
  rdl_id_t      exp_cmplt_q[$];
  int unsigned  exp_done;
  logic         cur_stb;
  logic         cur_way;
  logic         cur_inv;
  logic         cur_tag_clr;
  rdl_index_t   cur_idx;
  logic         beat_due;
  logic         req_held;
  logic         create_held;
  logic         busy;
  logic         last_due;
  rdl_arb_req_t prev_req;
  rdl_id_t      exp_id;

  // ==========================================================================
  // reference model
  // ==========================================================================

  // way in the top byte, set index in the middle, beat number in the low byte
  function automatic rdl_vb_beat_t expected_beat(input logic w, input rdl_index_t idx,
                                                 input rdl_beat_t b);
    rdl_vb_beat_t e;
    e.data        = '0;
    e.data[63:56] = {7'b0, w};
    e.data[17:8]  = idx;
    e.data[1:0]   = b;
    e.beat        = b;
    return e;
  endfunction

  function automatic rdl_vb_line_t expected_line(input rdl_tag_t tag, input rdl_index_t idx,
                                                 input logic dirty);
    rdl_vb_line_t l;
    l.addr  = {tag, idx};
    l.dirty = dirty;
    return l;
  endfunction

  function automatic rdl_way_oh_t way_onehot(input logic w);
    return w ? 2'b10 : 2'b01;
  endfunction

  task automatic expect_line_read(input logic w, input rdl_index_t idx, input rdl_vb_line_t l);
    int b;
    exp_line_q.push_back(l);
    for (b = 0; b < 4; b++) begin
      exp_beat_q.push_back(expected_beat(w, idx, rdl_beat_t'(b)));
    end
  endtask

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // ==========================================================================
  // compare process
  // ==========================================================================

  always @(negedge rdl_fsm_clk) begin
    if (!cpurst_b) begin
      compare("arb_req request bits", {arb_req.tag_req, arb_req.dirty_req, arb_req.data_req}, 0);
      compare("vb_create", vb_create, 0);
      compare("vb_beat_vld", vb_beat_vld, 0);
      compare("stb_cmplt", stb_cmplt, 0);
      compare("lfb_done", lfb_done, 0);
      compare("lfb_victim_save", lfb_victim_save, 0);
      exp_done    = 0;
      cur_stb     = 1'b0;
      beat_due    = 1'b0;
      req_held    = 1'b0;
      create_held = 1'b0;
      busy        = 1'b0;
      last_due    = 1'b0;
    end else begin
      // beat push owed by last cycle's data grant
      if (vb_beat_vld && !beat_due) begin
        report_error("vb_beat_vld without a data grant in the cycle before");
      end else if (beat_due) begin
        compare("vb_beat_vld", vb_beat_vld, 1'b1);
        compare("vb_beat", vb_beat, exp_beat_q[0]);
        exp_beat_q.pop_front();
      end
      beat_due = 1'b0;

      // ungranted requests hold
      if (req_held) compare("arb_req", arb_req, prev_req);
      req_held = (arb_req.tag_req | arb_req.dirty_req | arb_req.data_req) & ~arb_grant;
      prev_req = arb_req;
      if (create_held && !vb_create) report_error("vb_create dropped before vb_grant");
      create_held = vb_create & ~vb_grant;

      // grants only while no job is in flight, stb first
      compare("stb_grant", stb_grant, !busy);
      compare("lfb_grant", lfb_grant, !busy && !stb_start);

      // job acceptance
      if (stb_start && stb_grant) begin
        busy        = 1'b1;
        cur_stb     = 1'b1;
        cur_idx     = stb_req.line_addr[9:0];
        cur_way     = stb_req.way;
        cur_inv     = stb_req.inv | (stb_req.cln & stb_req.dirty);
        cur_tag_clr = stb_req.inv;
        exp_cmplt_q.push_back(stb_req.id);
        if (stb_req.cln && stb_req.dirty) begin
          expect_line_read(stb_req.way, cur_idx,
                           expected_line(stb_req.line_addr[26:10], cur_idx, 1'b1));
        end
      end else if (lfb_start && lfb_grant) begin
        busy    = 1'b1;
        cur_stb = 1'b0;
        cur_idx = lfb_index;
        cur_inv = 1'b0;
        exp_done++;
      end

      if (lfb_victim_save) begin
        compare("lfb_victim_way", lfb_victim_way, dc_victim_way);
        if (cur_stb) report_error("lfb_victim_save during an stb job");
        cur_way = dc_victim_way;
        if (rdl_tb.tbl_vld[dc_victim_way][cur_idx]) begin
          expect_line_read(dc_victim_way, cur_idx,
                           expected_line(rdl_tb.tbl_tag[dc_victim_way][cur_idx], cur_idx,
                                         rdl_tb.tbl_dirty[dc_victim_way][cur_idx]));
        end
      end

      if (vb_create) begin
        if (exp_line_q.size() == 0) begin
          report_error("vb_create with no victim line expected");
        end else begin
          compare("vb_line", vb_line, exp_line_q[0]);
          if (vb_grant) exp_line_q.pop_front();
        end
      end

      // tag read, or the dirty and tag clear
      if (arb_req.tag_req || arb_req.dirty_req) begin
        if ((arb_req.tag_wen == '0) && (arb_req.dirty_wen == '0)) begin
          if (cur_stb) report_error("tag read issued during an stb job");
          compare("arb_req.tag_req", arb_req.tag_req, 1'b1);
          compare("arb_req.dirty_req", arb_req.dirty_req, 1'b1);
          compare("arb_req.index", arb_req.index, cur_idx);
        end else if (!cur_stb || !cur_inv) begin
          report_error("dirty or tag clear issued for a job that needs none");
        end else begin
          compare("arb_req.dirty_req", arb_req.dirty_req, 1'b1);
          compare("arb_req.dirty_wen", arb_req.dirty_wen, way_onehot(cur_way));
          compare("arb_req.tag_req", arb_req.tag_req, cur_tag_clr);
          compare("arb_req.tag_wen", arb_req.tag_wen, cur_tag_clr ? way_onehot(cur_way) : 2'b00);
          compare("arb_req.index", arb_req.index, cur_idx);
          compare("stb_cmplt", stb_cmplt, arb_grant);
          if (exp_beat_q.size() != 0) report_error("line clear requested before all beats left");
        end
      end

      if (arb_req.data_req) begin
        if (exp_beat_q.size() == 0) begin
          report_error("data request with no line read expected");
        end else begin
          compare("arb_req.beat", arb_req.beat, exp_beat_q[0].beat);
          compare("arb_req.index", arb_req.index, cur_idx);
          compare("arb_req.data_way", arb_req.data_way, way_onehot(cur_way));
          beat_due = arb_grant;
        end
      end

      // completions
      if (last_due) begin
        busy     = 1'b0;
        last_due = 1'b0;
      end
      if (stb_cmplt) begin
        busy = 1'b0;
        if (exp_cmplt_q.size() == 0) begin
          report_error("stb_cmplt with no stb job open");
        end else begin
          exp_id = exp_cmplt_q.pop_front();
          compare("stb_cmplt_id", stb_cmplt_id, exp_id);
        end
        if (cur_inv && !(arb_req.dirty_req && arb_grant)) begin
          report_error("stb_cmplt outside a granted line clear");
        end
      end
      if (lfb_done) begin
        // a line read still passes through LAST before idle
        if (arb_req.data_req && arb_grant) begin
          last_due = 1'b1;
        end else begin
          busy = 1'b0;
        end
        if (exp_done == 0) report_error("lfb_done with no lfb job open");
        else exp_done--;
        if (exp_beat_q.size() > 1) report_error("lfb_done before the fourth data grant");
      end
    end
  end

  // anything still owed once the unit has gone idle
  task automatic finish_checks();
    if (exp_cmplt_q.size() != 0) report_error("missing completion: stb_cmplt never seen");
    if (exp_done != 0) report_error("missing completion: lfb_done never seen");
    if (exp_line_q.size() != 0) report_error("missing completion: vb_create never granted");
    if (exp_beat_q.size() != 0) report_error("missing completion: victim beats not pushed");
  endtask

endmodule

// ==== sim/rdl_tb.sv ====
// random grants and a one-cycle array return; the tag table is filled once and read by the checker
`timescale 1ns/1ps

module rdl_tb import rdl_pkg::*; ();

  localparam int         N_RAND   = 24;
  localparam int         NUM_JOBS = 7 + N_RAND;
  localparam rdl_index_t VLD_SET  = 10'h155;
  localparam rdl_index_t INV_SET  = 10'h2aa;

  logic         rdl_fsm_clk;
  logic         cpurst_b;
  logic         stb_start;
  rdl_stb_req_t stb_req;
  logic         lfb_start;
  rdl_index_t   lfb_index;
  logic         arb_grant;
  rdl_way_rd_t  way0_rd;
  rdl_way_rd_t  way1_rd;
  logic         dc_victim_way;
  logic         vb_grant;
  logic         stb_grant;
  logic         stb_cmplt;
  rdl_id_t      stb_cmplt_id;
  logic         lfb_grant;
  logic         lfb_done;
  logic         lfb_victim_save;
  logic         lfb_victim_way;
  rdl_arb_req_t arb_req;
  logic         vb_create;
  rdl_vb_line_t vb_line;
  rdl_vb_beat_t vb_beat;
  logic         vb_beat_vld;

  // per way and set
  logic         tbl_vld   [0:1][0:1023];
  logic         tbl_dirty [0:1][0:1023];
  rdl_tag_t     tbl_tag   [0:1][0:1023];

  logic         rd_hit;
  logic         data_hit;
  rdl_index_t   hit_idx;
  rdl_beat_t    hit_beat;
  int           j;

  rdl_top dut (.*);

  rdl_checker chk (.*);

  initial rdl_fsm_clk = 1'b0;
  always #4 rdl_fsm_clk = ~rdl_fsm_clk;

  // ==========================================================================
  // array and victim buffer responders
  // ==========================================================================

  function automatic rdl_data_t beat_word(input logic w, input rdl_index_t idx,
                                          input rdl_beat_t b);
    return {8'(w), 32'h0, 6'h0, idx, 6'h0, b};
  endfunction

  function automatic rdl_way_rd_t way_return(input logic w);
    rdl_way_rd_t r;
    r.vld   = rd_hit ? tbl_vld[w][hit_idx] : 1'($urandom);
    r.dirty = rd_hit ? tbl_dirty[w][hit_idx] : 1'($urandom);
    r.tag   = rd_hit ? tbl_tag[w][hit_idx] : rdl_tag_t'($urandom);
    r.data  = data_hit ? beat_word(w, hit_idx, hit_beat) : {$urandom, $urandom};
    return r;
  endfunction

  // grant seen before the edge, data back in the following cycle
  always begin
    @(negedge rdl_fsm_clk);
    rd_hit   = arb_grant & arb_req.tag_req & arb_req.dirty_req &
               (arb_req.tag_wen == '0) & (arb_req.dirty_wen == '0);
    data_hit = arb_grant & arb_req.data_req;
    hit_idx  = arb_req.index;
    hit_beat = arb_req.beat;
    @(posedge rdl_fsm_clk);
    #1;
    way0_rd       = way_return(1'b0);
    way1_rd       = way_return(1'b1);
    dc_victim_way = 1'($urandom);
    arb_grant     = ($urandom_range(3) != 0);
    vb_grant      = ($urandom_range(2) != 0);
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  task automatic fill_table();
    int i;
    int w;
    for (w = 0; w < 2; w++) begin
      for (i = 0; i < 1024; i++) begin
        tbl_vld[w][i]   = ($urandom_range(3) != 0);
        tbl_dirty[w][i] = 1'($urandom);
        tbl_tag[w][i]   = rdl_tag_t'($urandom);
      end
    end
    // one set full and one set empty for the directed lfb jobs
    tbl_vld[0][VLD_SET] = 1'b1;
    tbl_vld[1][VLD_SET] = 1'b1;
    tbl_vld[0][INV_SET] = 1'b0;
    tbl_vld[1][INV_SET] = 1'b0;
  endtask

  function automatic rdl_stb_req_t make_req(input logic cln, input logic inv, input logic dirty);
    rdl_stb_req_t r;
    r.line_addr = rdl_line_addr_t'($urandom);
    r.cln       = cln;
    r.inv       = inv;
    r.dirty     = dirty;
    r.way       = 1'($urandom);
    r.id        = rdl_id_t'($urandom);
    return r;
  endfunction

  // holds each start until its grant, entered and left just after a rising edge
  task automatic start_jobs(input logic do_stb, input rdl_stb_req_t req,
                            input logic do_lfb, input rdl_index_t idx);
    logic stb_acc;
    logic lfb_acc;
    stb_start = do_stb;
    stb_req   = req;
    lfb_start = do_lfb;
    lfb_index = idx;
    while (stb_start || lfb_start) begin
      @(negedge rdl_fsm_clk);
      stb_acc = stb_start & stb_grant;
      lfb_acc = lfb_start & lfb_grant;
      @(posedge rdl_fsm_clk);
      #1;
      if (stb_acc) stb_start = 1'b0;
      if (lfb_acc) lfb_start = 1'b0;
    end
  endtask

  task automatic wait_idle();
    do @(negedge rdl_fsm_clk); while (!stb_grant);
    @(posedge rdl_fsm_clk);
    #1;
  endtask

  initial begin
    void'($urandom(32'hf50a));
    cpurst_b      = 1'b0;
    stb_start     = 1'b0;
    stb_req       = '0;
    lfb_start     = 1'b0;
    lfb_index     = '0;
    arb_grant     = 1'b0;
    vb_grant      = 1'b0;
    way0_rd       = '0;
    way1_rd       = '0;
    dc_victim_way = 1'b0;
    fill_table();
    repeat (2) @(posedge rdl_fsm_clk);
    #1;
    cpurst_b = 1'b1;
    @(posedge rdl_fsm_clk);
    #1;

    start_jobs(1'b0, '0, 1'b1, VLD_SET);
    start_jobs(1'b0, '0, 1'b1, INV_SET);
    // clean and invalidate of a dirty line
    start_jobs(1'b1, make_req(1'b1, 1'b1, 1'b1), 1'b0, '0);
    start_jobs(1'b1, make_req(1'b0, 1'b1, 1'b0), 1'b0, '0);
    start_jobs(1'b1, make_req(1'b1, 1'b0, 1'b0), 1'b0, '0);
    // both sources in the same idle cycle
    wait_idle();
    start_jobs(1'b1, make_req(1'b1, 1'b0, 1'b1), 1'b1, VLD_SET);

    for (j = 0; j < N_RAND; j++) begin
      if ($urandom_range(1) != 0) begin
        start_jobs(1'b1, make_req(1'($urandom), 1'($urandom), 1'($urandom)), 1'b0, '0);
      end else begin
        start_jobs(1'b0, '0, 1'b1, rdl_index_t'($urandom));
      end
    end

    wait_idle();
    chk.finish_checks();
    $display("jobs: %0d  checks: %0d  errors: %0d", NUM_JOBS, chk.check_cnt, chk.err_cnt);
    if (chk.err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (NUM_JOBS * 80) @(posedge rdl_fsm_clk);
    $display("timeout: %0d jobs did not finish within %0d cycles", NUM_JOBS, NUM_JOBS * 80);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+logic
logic/rdl_pkg.sv
logic/rdl_fsm.sv
logic/rdl_target_reg.sv
logic/rdl_array_access.sv
logic/rdl_top.sv
sim/rdl_checker.sv
sim/rdl_tb.sv
